// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_writeback -f writeback.f

# The log decides the result, an aborted run has no pass line
run: compile
	./obj_dir/Vtb_writeback > sim.log 2>&1 ; cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi
	@grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: src/load_aligner.sv
// Load aligner: lane select from a cache line, sub-word extraction, sign extension, lane byte swap
`timescale 1ns/100ps

module load_aligner #(
	parameter int NUM_LANES = writeback_pkg::NUM_LANES
) (
	input  logic [NUM_LANES*writeback_pkg::LANE_WIDTH-1:0]	ddata_i,
	input  logic [$clog2(NUM_LANES)-1:0]					cache_lane_select_i,
	input  logic [1:0]										addr_low_i,
	input  logic [3:0]										load_width_i,
	output logic [writeback_pkg::LANE_WIDTH-1:0]			aligned_o,
	output logic [NUM_LANES*writeback_pkg::LANE_WIDTH-1:0]	swapped_line_o
);
	import writeback_pkg::*;

	logic [LANE_WIDTH-1:0]	lane_value;
	logic [LANE_WIDTH-1:0]	word_value;
	logic [15:0]			half_aligned;
	logic [7:0]				byte_aligned;

	// Lane 0 occupies the top bits of the line
	assign lane_value = ddata_i[(NUM_LANES - 1 - cache_lane_select_i) * LANE_WIDTH +: LANE_WIDTH];

	// Memory byte 0 is the most significant byte of the lane
	assign word_value = {lane_value[7:0], lane_value[15:8], lane_value[23:16], lane_value[31:24]};

	always_comb
	begin
		case (addr_low_i)
			2'b00: byte_aligned = lane_value[31:24];
			2'b01: byte_aligned = lane_value[23:16];
			2'b10: byte_aligned = lane_value[15:8];
			default: byte_aligned = lane_value[7:0];
		endcase
	end

	// Halfwords swap their two bytes, only bit 1 of the address matters
	always_comb
	begin
		if (addr_low_i[1])
			half_aligned = {lane_value[7:0], lane_value[15:8]};
		else
			half_aligned = {lane_value[23:16], lane_value[31:24]};
	end

	// Extend by load width
	always_comb
	begin
		case (load_width_i)
			LOAD_UBYTE: aligned_o = {24'b0, byte_aligned};
			LOAD_SBYTE: aligned_o = {{24{byte_aligned[7]}}, byte_aligned};
			LOAD_UHALF: aligned_o = {16'b0, half_aligned};
			LOAD_SHALF: aligned_o = {{16{half_aligned[15]}}, half_aligned};
			LOAD_WORD: aligned_o = word_value;
			// Strided and gather lanes read back as whole words too
			default: aligned_o = word_value;
		endcase
	end

	// Block loads: every lane byte-reversed in place
	for (genvar lane = 0; lane < NUM_LANES; lane++)
	begin : g_swap
		assign swapped_line_o[lane*LANE_WIDTH +: LANE_WIDTH] = {
			ddata_i[lane*LANE_WIDTH +: 8],
			ddata_i[lane*LANE_WIDTH + 8 +: 8],
			ddata_i[lane*LANE_WIDTH + 16 +: 8],
			ddata_i[lane*LANE_WIDTH + 24 +: 8]
		};
	end

endmodule

// File: src/vector_register_file.sv
// Scalar and vector register file with masked lane writes and a combinational read port
`timescale 1ns/100ps

module vector_register_file #(
	parameter int NUM_LANES = writeback_pkg::NUM_LANES
) (
	input  logic											clk,
	input  logic											reset_i,
	input  logic											wb_enable_i,
	input  logic [writeback_pkg::REG_INDEX_WIDTH-1:0]		wb_reg_i,
	input  logic											wb_is_vector_i,
	input  logic [NUM_LANES*writeback_pkg::LANE_WIDTH-1:0]	wb_value_i,
	input  logic [NUM_LANES-1:0]							wb_mask_i,
	input  logic [writeback_pkg::REG_INDEX_WIDTH-1:0]		rd_reg_i,
	input  logic											rd_is_vector_i,
	output logic [NUM_LANES*writeback_pkg::LANE_WIDTH-1:0]	rd_value_o
);
	import writeback_pkg::*;

	localparam int NUM_REGS = 1 << REG_INDEX_WIDTH;

	logic [LANE_WIDTH-1:0]				scalar_regs [NUM_REGS];
	logic [NUM_LANES*LANE_WIDTH-1:0]	vector_regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int r = 0; r < NUM_REGS; r++)
			begin
				scalar_regs[r] <= '0;
				vector_regs[r] <= '0;
			end
		end
		else if (wb_enable_i)
		begin
			if (wb_is_vector_i)
			begin
				// Mask bit n guards lane bits n*32 upward
				for (int l = 0; l < NUM_LANES; l++)
				begin
					if (wb_mask_i[l])
						vector_regs[wb_reg_i][l*LANE_WIDTH +: LANE_WIDTH] <=
							wb_value_i[l*LANE_WIDTH +: LANE_WIDTH];
				end
			end
			else
			begin
				// Scalar takes the lowest lane
				scalar_regs[wb_reg_i] <= wb_value_i[LANE_WIDTH-1:0];
			end
		end
	end

	// Scalars read back broadcast across the lanes
	assign rd_value_o = rd_is_vector_i ? vector_regs[rd_reg_i]
		: {NUM_LANES{scalar_regs[rd_reg_i]}};

	// PC updates arrive as rollbacks, never through the commit path
	a_no_pc_write: assert property (@(posedge clk) disable iff (reset_i)
		(wb_enable_i && !wb_is_vector_i) |-> wb_reg_i != PC_REG);

endmodule

// File: src/writeback_pkg.sv
// Writeback package: lane geometry, register index widths, load-width and class codes

package writeback_pkg;

	// Lane geometry
	localparam int NUM_LANES = 16;
	localparam int LANE_WIDTH = 32;

	// Register indexing
	localparam int REG_INDEX_WIDTH = 5;

	// Scalar register 31 is the program counter
	localparam logic [REG_INDEX_WIDTH-1:0] PC_REG = 5'd31;

	// Instruction class in bits 31:30
	localparam logic [1:0] MEM_CLASS = 2'd2;

	// Load/store select within a memory instruction
	localparam int LOAD_BIT = 29;

	// Load width field, instruction bits 28:25
	localparam logic [3:0] LOAD_UBYTE = 4'd0;
	localparam logic [3:0] LOAD_SBYTE = 4'd1;
	localparam logic [3:0] LOAD_UHALF = 4'd2;
	localparam logic [3:0] LOAD_SHALF = 4'd3;
	localparam logic [3:0] LOAD_WORD = 4'd4;

	// Control register transfer, not a real load
	localparam logic [3:0] LOAD_CONTROL = 4'd6;

	// Whole-line block loads
	localparam logic [3:0] LOAD_BLOCK = 4'd7;
	localparam logic [3:0] LOAD_BLOCK_MASKED = 4'd8;
	localparam logic [3:0] LOAD_BLOCK_INV_MASKED = 4'd9;

	// Codes 10 and above are strided or gather, one lane per access

endpackage

// File: src/writeback_stage.sv
// Writeback stage: source select, lane mask, rollback and suspend requests, commit register
`timescale 1ns/100ps

module writeback_stage #(
	parameter int NUM_LANES = writeback_pkg::NUM_LANES
) (
	input  logic											clk,
	input  logic											reset_i,
	input  logic [31:0]										instruction_i,
	input  logic [writeback_pkg::LANE_WIDTH-1:0]			pc_i,
	input  logic [writeback_pkg::REG_INDEX_WIDTH-1:0]		writeback_reg_i,
	input  logic											writeback_is_vector_i,
	input  logic											has_writeback_i,
	input  logic [NUM_LANES-1:0]							mask_i,
	input  logic											cache_hit_i,
	input  logic											was_access_i,
	input  logic [NUM_LANES*writeback_pkg::LANE_WIDTH-1:0]	ddata_i,
	input  logic [NUM_LANES*writeback_pkg::LANE_WIDTH-1:0]	result_i,
	input  logic [$clog2(NUM_LANES)-1:0]					reg_lane_select_i,
	input  logic [$clog2(NUM_LANES)-1:0]					cache_lane_select_i,
	output logic											wb_enable_o,
	output logic [writeback_pkg::REG_INDEX_WIDTH-1:0]		wb_reg_o,
	output logic											wb_is_vector_o,
	output logic [NUM_LANES*writeback_pkg::LANE_WIDTH-1:0]	wb_value_o,
	output logic [NUM_LANES-1:0]							wb_mask_o,
	output logic											rollback_request_o,
	output logic [writeback_pkg::LANE_WIDTH-1:0]			rollback_address_o,
	output logic											suspend_request_o
);
	import writeback_pkg::*;

	localparam int LINE_WIDTH = NUM_LANES * LANE_WIDTH;
	localparam logic [NUM_LANES-1:0] TOP_LANE_MASK = {1'b1, {(NUM_LANES - 1){1'b0}}};

	logic [3:0]				load_width;
	logic					is_mem;
	logic					is_ctrl_xfer;
	logic					is_load;
	logic					is_block_load;
	logic					cache_miss;
	logic					pc_load;
	logic [LANE_WIDTH-1:0]	aligned_value;
	logic [LINE_WIDTH-1:0]	swapped_line;
	logic [LINE_WIDTH-1:0]	value_nxt;
	logic [NUM_LANES-1:0]	mask_nxt;

	// Instruction decode
	assign load_width = instruction_i[28:25];
	assign is_mem = instruction_i[31:30] == MEM_CLASS;
	assign is_ctrl_xfer = is_mem && load_width == LOAD_CONTROL;
	assign is_load = is_mem && instruction_i[LOAD_BIT] && !is_ctrl_xfer;
	assign is_block_load = load_width == LOAD_BLOCK || load_width == LOAD_BLOCK_MASKED
		|| load_width == LOAD_BLOCK_INV_MASKED;

	assign cache_miss = is_load && was_access_i && !cache_hit_i;
	assign pc_load = is_load && has_writeback_i && !writeback_is_vector_i
		&& writeback_reg_i == PC_REG;

	// result_i still holds the effective address for loads
	load_aligner #(
		.NUM_LANES(NUM_LANES)
	) u_aligner (
		.ddata_i(ddata_i),
		.cache_lane_select_i(cache_lane_select_i),
		.addr_low_i(result_i[1:0]),
		.load_width_i(load_width),
		.aligned_o(aligned_value),
		.swapped_line_o(swapped_line)
	);

	// Load into PC beats a miss
	always_comb
	begin
		rollback_request_o = 1'b0;
		rollback_address_o = '0;
		if (pc_load)
		begin
			rollback_request_o = 1'b1;
			rollback_address_o = aligned_value;
		end
		else if (cache_miss)
		begin
			rollback_request_o = 1'b1;
			rollback_address_o = pc_i - 32'd4;
		end
	end

	// Item is replayed once the line arrives
	assign suspend_request_o = cache_miss && !pc_load;

	always_comb
	begin
		if (!is_load)
		begin
			value_nxt = result_i;
			mask_nxt = mask_i;
		end
		else if (load_width < LOAD_BLOCK)
		begin
			// Scalar load broadcast to every lane
			value_nxt = {NUM_LANES{aligned_value}};
			mask_nxt = '1;
		end
		else if (is_block_load)
		begin
			value_nxt = swapped_line;
			mask_nxt = mask_i;
		end
		else
		begin
			// Strided or gather loads write one lane counted from the top
			value_nxt = {NUM_LANES{aligned_value}};
			mask_nxt = (TOP_LANE_MASK >> reg_lane_select_i) & mask_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			wb_enable_o <= 1'b0;
		else
			wb_enable_o <= has_writeback_i && !cache_miss && !pc_load;
	end

	always_ff @(posedge clk)
	begin
		wb_reg_o <= writeback_reg_i;
		wb_is_vector_o <= writeback_is_vector_i;
		wb_value_o <= value_nxt;
		wb_mask_o <= mask_nxt;
	end

	a_lane_select_range: assert property (@(posedge clk) disable iff (reset_i)
		(has_writeback_i && is_load) |->
			(cache_lane_select_i < NUM_LANES) && (reg_lane_select_i < NUM_LANES));

endmodule

// File: src/writeback_top.sv
// Top level: writeback stage feeding the register file
`timescale 1ns/100ps

module writeback_top #(
	parameter int NUM_LANES = writeback_pkg::NUM_LANES
) (
	input  logic											clk,
	input  logic											reset_i,
	input  logic [31:0]										instruction_i,
	input  logic [writeback_pkg::LANE_WIDTH-1:0]			pc_i,
	input  logic [writeback_pkg::REG_INDEX_WIDTH-1:0]		writeback_reg_i,
	input  logic											writeback_is_vector_i,
	input  logic											has_writeback_i,
	input  logic [NUM_LANES-1:0]							mask_i,
	input  logic											cache_hit_i,
	input  logic											was_access_i,
	input  logic [NUM_LANES*writeback_pkg::LANE_WIDTH-1:0]	ddata_i,
	input  logic [NUM_LANES*writeback_pkg::LANE_WIDTH-1:0]	result_i,
	input  logic [$clog2(NUM_LANES)-1:0]					reg_lane_select_i,
	input  logic [$clog2(NUM_LANES)-1:0]					cache_lane_select_i,
	output logic											rollback_request_o,
	output logic [writeback_pkg::LANE_WIDTH-1:0]			rollback_address_o,
	output logic											suspend_request_o,
	input  logic [writeback_pkg::REG_INDEX_WIDTH-1:0]		rd_reg_i,
	input  logic											rd_is_vector_i,
	output logic [NUM_LANES*writeback_pkg::LANE_WIDTH-1:0]	rd_value_o
);
	import writeback_pkg::*;

	// Commit path
	logic								wb_enable;
	logic [REG_INDEX_WIDTH-1:0]			wb_reg;
	logic								wb_is_vector;
	logic [NUM_LANES*LANE_WIDTH-1:0]	wb_value;
	logic [NUM_LANES-1:0]				wb_mask;

	writeback_stage #(
		.NUM_LANES(NUM_LANES)
	) u_stage (
		.clk(clk),
		.reset_i(reset_i),
		.instruction_i(instruction_i),
		.pc_i(pc_i),
		.writeback_reg_i(writeback_reg_i),
		.writeback_is_vector_i(writeback_is_vector_i),
		.has_writeback_i(has_writeback_i),
		.mask_i(mask_i),
		.cache_hit_i(cache_hit_i),
		.was_access_i(was_access_i),
		.ddata_i(ddata_i),
		.result_i(result_i),
		.reg_lane_select_i(reg_lane_select_i),
		.cache_lane_select_i(cache_lane_select_i),
		.wb_enable_o(wb_enable),
		.wb_reg_o(wb_reg),
		.wb_is_vector_o(wb_is_vector),
		.wb_value_o(wb_value),
		.wb_mask_o(wb_mask),
		.rollback_request_o(rollback_request_o),
		.rollback_address_o(rollback_address_o),
		.suspend_request_o(suspend_request_o)
	);

	vector_register_file #(
		.NUM_LANES(NUM_LANES)
	) u_regfile (
		.clk(clk),
		.reset_i(reset_i),
		.wb_enable_i(wb_enable),
		.wb_reg_i(wb_reg),
		.wb_is_vector_i(wb_is_vector),
		.wb_value_i(wb_value),
		.wb_mask_i(wb_mask),
		.rd_reg_i(rd_reg_i),
		.rd_is_vector_i(rd_is_vector_i),
		.rd_value_o(rd_value_o)
	);

endmodule

// File: tests/tb_writeback.sv
// Testbench: clock, reset, seeded random stimulus, reference model, watchdog and summary
`timescale 1ns/100ps

module tb_writeback;
	import writeback_pkg::*;

	localparam int LANES = 16;
	localparam int LINE = LANES * LANE_WIDTH;
	localparam int SEED = 88319;
	localparam int ITEMS = 40;
	localparam int NUM_TESTS = 6;
	localparam int TOTAL_ITEMS = 64 + 5 * ITEMS;
	localparam int TIMEOUT_NS = (TOTAL_ITEMS * 20 + 100) * 20;

	logic					clk;
	logic					reset_i;
	logic [31:0]			instruction_i;
	logic [31:0]			pc_i;
	logic [4:0]				writeback_reg_i;
	logic					writeback_is_vector_i;
	logic					has_writeback_i;
	logic [LANES-1:0]		mask_i;
	logic					cache_hit_i;
	logic					was_access_i;
	logic [LINE-1:0]		ddata_i;
	logic [LINE-1:0]		result_i;
	logic [3:0]				reg_lane_select_i;
	logic [3:0]				cache_lane_select_i;
	logic					rollback_request_o;
	logic [31:0]			rollback_address_o;
	logic					suspend_request_o;
	logic [4:0]				rd_reg_i;
	logic					rd_is_vector_i;
	logic [LINE-1:0]		rd_value_o;

	// Expectations handed to the checker
	logic					chk_flow;
	logic					exp_rollback;
	logic [31:0]			exp_address;
	logic					exp_suspend;
	logic					chk_read;
	logic [LINE-1:0]		exp_value;
	logic [2:0]				test_id;
	logic					test_end;
	int						tests_failed;
	int						error_count;

	// Shadow of the register file
	logic [31:0]			scalar_shadow [32];
	logic [LINE-1:0]		vector_shadow [32];

	writeback_top #(
		.NUM_LANES(LANES)
	) u_dut (.*);

	wb_checker #(
		.LINE_WIDTH(LINE)
	) u_checker (
		.clk(clk),
		.reset_i(reset_i),
		.rollback_request_i(rollback_request_o),
		.rollback_address_i(rollback_address_o),
		.suspend_request_i(suspend_request_o),
		.rd_value_i(rd_value_o),
		.chk_flow_i(chk_flow),
		.exp_rollback_i(exp_rollback),
		.exp_address_i(exp_address),
		.exp_suspend_i(exp_suspend),
		.chk_read_i(chk_read),
		.exp_value_i(exp_value),
		.test_id_i(test_id),
		.test_end_i(test_end),
		.tests_failed_o(tests_failed),
		.errors_o(error_count)
	);

	// Lane 0 sits in the top word of the line
	function automatic logic [31:0] pick_lane(input logic [LINE-1:0] line, input int sel);
		return line[(LANES - 1 - sel) * 32 +: 32];
	endfunction

	// Memory byte k is the k-th byte from the top of a lane
	function automatic logic [7:0] mem_byte(input logic [31:0] w, input int k);
		return w[31 - 8 * k -: 8];
	endfunction

	function automatic logic [31:0] load_value(input logic [31:0] w, input logic [3:0] width,
		input logic [1:0] off);
		logic [7:0]		b;
		logic [15:0]	h;
		b = mem_byte(w, off);
		h = {mem_byte(w, {off[1], 1'b1}), mem_byte(w, {off[1], 1'b0})};
		case (width)
			LOAD_UBYTE: return {24'b0, b};
			LOAD_SBYTE: return {{24{b[7]}}, b};
			LOAD_UHALF: return {16'b0, h};
			LOAD_SHALF: return {{16{h[15]}}, h};
			default: return {mem_byte(w, 3), mem_byte(w, 2), mem_byte(w, 1), mem_byte(w, 0)};
		endcase
	endfunction

	// Block loads see every lane as a word load
	function automatic logic [LINE-1:0] swap_lanes(input logic [LINE-1:0] line);
		logic [LINE-1:0] s;
		for (int n = 0; n < LANES; n++)
			s[(LANES - 1 - n) * 32 +: 32] = load_value(pick_lane(line, n), LOAD_WORD, 2'b00);
		return s;
	endfunction

	function automatic logic [LINE-1:0] random_line();
		logic [LINE-1:0] l;
		for (int n = 0; n < LANES; n++)
			l[n * 32 +: 32] = $urandom;
		return l;
	endfunction

	function automatic logic [31:0] load_instr(input logic [3:0] width);
		return {MEM_CLASS, 1'b1, width, 25'($urandom)};
	endfunction

	// Memory class only as a store or a control register transfer
	function automatic logic [31:0] alu_instr();
		logic [31:0] i;
		i = $urandom;
		if (i[31:30] == MEM_CLASS)
		begin
			if (i[0])
				i[28:25] = LOAD_CONTROL;
			else
				i[LOAD_BIT] = 1'b0;
		end
		return i;
	endfunction

	function automatic logic [LINE-1:0] shadow_read(input logic [4:0] r, input logic vec);
		return vec ? vector_shadow[r] : {LANES{scalar_shadow[r]}};
	endfunction

	task automatic apply_commit(input logic [4:0] r, input logic vec,
		input logic [LINE-1:0] value, input logic [LANES-1:0] mask);
		if (vec)
		begin
			for (int n = 0; n < LANES; n++)
			begin
				if (mask[n])
					vector_shadow[r][n * 32 +: 32] = value[n * 32 +: 32];
			end
		end
		else
			scalar_shadow[r] = value[31:0];
	endtask

	task automatic check_read(input logic [4:0] r, input logic vec);
		@(negedge clk);
		rd_reg_i = r;
		rd_is_vector_i = vec;
		chk_flow = 1'b1;
		exp_rollback = 1'b0;
		exp_suspend = 1'b0;
		chk_read = 1'b1;
		exp_value = shadow_read(r, vec);
	endtask

	// One item, an idle cycle while it commits, then its destination is read back
	task automatic run_item(input logic [31:0] instr, input logic [4:0] r, input logic vec,
		input logic hit, input logic acc, input logic has_wb);
		logic [3:0]			width;
		logic				load;
		logic				miss;
		logic				pc_load;
		logic [31:0]		aligned;
		logic [LANES-1:0]	lane_bit;
		width = instr[28:25];
		load = instr[31:30] == MEM_CLASS && instr[LOAD_BIT] && width != LOAD_CONTROL;
		@(negedge clk);
		chk_read = 1'b0;
		instruction_i = instr;
		writeback_reg_i = r;
		writeback_is_vector_i = vec;
		has_writeback_i = has_wb;
		cache_hit_i = hit;
		was_access_i = acc;
		ddata_i = random_line();
		result_i = random_line();
		mask_i = 16'($urandom);
		pc_i = $urandom;
		reg_lane_select_i = 4'($urandom);
		cache_lane_select_i = 4'($urandom);
		rd_reg_i = r;
		rd_is_vector_i = vec;
		aligned = load_value(pick_lane(ddata_i, cache_lane_select_i), width, result_i[1:0]);
		pc_load = load && has_wb && !vec && r == PC_REG;
		miss = load && acc && !hit;
		chk_flow = 1'b1;
		exp_rollback = pc_load || miss;
		exp_suspend = miss && !pc_load;
		exp_address = pc_load ? aligned : pc_i - 32'd4;
		lane_bit = '0;
		lane_bit[LANES - 1 - reg_lane_select_i] = 1'b1;
		if (has_wb && !pc_load && !miss)
		begin
			if (!load)
				apply_commit(r, vec, result_i, mask_i);
			else if (width < LOAD_BLOCK)
				apply_commit(r, vec, {LANES{aligned}}, '1);
			else if (width <= LOAD_BLOCK_INV_MASKED)
				apply_commit(r, vec, swap_lanes(ddata_i), mask_i);
			else
				apply_commit(r, vec, {LANES{aligned}}, mask_i & lane_bit);
		end
		@(negedge clk);
		instruction_i = '0;
		has_writeback_i = 1'b0;
		was_access_i = 1'b0;
		exp_rollback = 1'b0;
		exp_suspend = 1'b0;
		check_read(r, vec);
	endtask

	task automatic finish_test();
		@(negedge clk);
		chk_flow = 1'b0;
		chk_read = 1'b0;
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Watchdog sized from the item count
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("tests failed");
		$finish;
	end

	initial
	begin
		logic		vec;
		logic [4:0]	r;
		void'($urandom(SEED));
		reset_i = 1'b1;
		instruction_i = '0;
		pc_i = '0;
		writeback_reg_i = '0;
		writeback_is_vector_i = 1'b0;
		has_writeback_i = 1'b0;
		mask_i = '0;
		cache_hit_i = 1'b0;
		was_access_i = 1'b0;
		ddata_i = '0;
		result_i = '0;
		reg_lane_select_i = '0;
		cache_lane_select_i = '0;
		rd_reg_i = '0;
		rd_is_vector_i = 1'b0;
		chk_flow = 1'b0;
		exp_rollback = 1'b0;
		exp_address = '0;
		exp_suspend = 1'b0;
		chk_read = 1'b0;
		exp_value = '0;
		test_id = 3'd0;
		test_end = 1'b0;
		for (int i = 0; i < 32; i++)
		begin
			scalar_shadow[i] = '0;
			vector_shadow[i] = '0;
		end
		repeat (8) @(negedge clk);
		reset_i = 1'b0;

		// Every register cleared, no rollback while idle
		test_id = 3'd0;
		for (int i = 0; i < 64; i++)
			check_read(5'(i % 32), i >= 32);
		finish_test();

		test_id = 3'd1;
		for (int i = 0; i < ITEMS; i++)
			run_item(load_instr(4'($urandom_range(0, 3))), 5'($urandom_range(0, 30)),
				1'b0, 1'b1, 1'b1, 1'b1);
		finish_test();

		test_id = 3'd2;
		for (int i = 0; i < ITEMS; i++)
		begin
			vec = 1'($urandom);
			r = vec ? 5'($urandom) : 5'($urandom_range(0, 30));
			if (i % 2 == 0)
				run_item(load_instr(LOAD_WORD), 5'($urandom_range(0, 30)),
					1'b0, 1'b1, 1'b1, 1'b1);
			else
				run_item(alu_instr(), r, vec, 1'($urandom), 1'($urandom),
					$urandom_range(0, 3) != 0);
		end
		finish_test();

		test_id = 3'd3;
		for (int i = 0; i < ITEMS; i++)
			run_item(load_instr(4'($urandom_range(7, 9))), 5'($urandom), 1'b1, 1'b1, 1'b1, 1'b1);
		finish_test();

		test_id = 3'd4;
		for (int i = 0; i < ITEMS; i++)
			run_item(load_instr(4'($urandom_range(10, 15))), 5'($urandom),
				1'b1, 1'b1, 1'b1, 1'b1);
		finish_test();

		// Misses, PC loads, and PC loads that also miss
		test_id = 3'd5;
		for (int i = 0; i < ITEMS; i++)
		begin
			vec = 1'($urandom);
			r = vec ? 5'($urandom) : 5'($urandom_range(0, 30));
			if ($urandom_range(0, 2) == 0)
				run_item(load_instr(4'($urandom_range(0, 15))), r, vec, 1'b0, 1'b1, 1'b1);
			else
				run_item(load_instr(4'($urandom_range(0, 4))), PC_REG, 1'b0,
					1'($urandom), 1'b1, 1'b1);
		end
		finish_test();

		$display("Summary: %0d tests run, %0d passed, %0d failed, %0d errors",
			NUM_TESTS, NUM_TESTS - tests_failed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: tests/wb_checker.sv
// Checker: compares DUT rollback, suspend and read-back values with expectations, reports per test
`timescale 1ns/100ps

module wb_checker #(
	parameter int LINE_WIDTH = 512
) (
	input  logic					clk,
	input  logic					reset_i,
	input  logic					rollback_request_i,
	input  logic [31:0]				rollback_address_i,
	input  logic					suspend_request_i,
	input  logic [LINE_WIDTH-1:0]	rd_value_i,
	input  logic					chk_flow_i,
	input  logic					exp_rollback_i,
	input  logic [31:0]				exp_address_i,
	input  logic					exp_suspend_i,
	input  logic					chk_read_i,
	input  logic [LINE_WIDTH-1:0]	exp_value_i,
	input  logic [2:0]				test_id_i,
	input  logic					test_end_i,
	output int						tests_failed_o,
	output int						errors_o
);
	int test_errors = 0;
	int error_count = 0;
	int failed_count = 0;

	assign tests_failed_o = failed_count;
	assign errors_o = error_count;

	function automatic string name_of(input logic [2:0] id);
		case (id)
			3'd0: return "reset state";
			3'd1: return "scalar sub-word loads";
			3'd2: return "word loads and arithmetic";
			3'd3: return "block loads";
			3'd4: return "strided and gather loads";
			3'd5: return "rollback and suspend";
			default: return "unknown";
		endcase
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		test_errors++;
		error_count++;
	endtask

	// Inputs and expectations settle on the falling edge
	always @(posedge clk)
	begin
		if (!reset_i && chk_flow_i)
		begin
			if (rollback_request_i !== exp_rollback_i)
				report_mismatch($sformatf("rollback request %0b, expected %0b",
					rollback_request_i, exp_rollback_i));
			else if (exp_rollback_i && rollback_address_i !== exp_address_i)
				report_mismatch($sformatf("rollback address %h, expected %h",
					rollback_address_i, exp_address_i));
			if (suspend_request_i !== exp_suspend_i)
				report_mismatch($sformatf("suspend request %0b, expected %0b",
					suspend_request_i, exp_suspend_i));
		end
		if (!reset_i && chk_read_i && rd_value_i !== exp_value_i)
			report_mismatch($sformatf("read-back %h, expected %h", rd_value_i, exp_value_i));
		if (test_end_i)
		begin
			if (test_errors == 0)
				$display("Test %s: passed", name_of(test_id_i));
			else
			begin
				$display("Test %s: FAILED with %0d errors", name_of(test_id_i), test_errors);
				failed_count++;
			end
			test_errors = 0;
		end
	end

endmodule

// File: writeback.f
src/writeback_pkg.sv
src/load_aligner.sv
src/writeback_stage.sv
src/vector_register_file.sv
src/writeback_top.sv
tests/wb_checker.sv
tests/tb_writeback.sv
